/* design/smc_types_pkg.sv */
package smc_types_pkg;

  // ============================================================
  // device and result counts
  // ============================================================

  localparam int NUM_DEVICES = 6;

  // values taken from the sorted list for the average
  localparam int NUM_PICKED = 3;

  // ============================================================
  // data widths
  // ============================================================

  // width and voltage codes of one device
  typedef logic [2:0] volt_t;

  // scaled Id or gm of one device, at most 36 * 7
  typedef logic [7:0] metric_t;

  // one picked value after the divide by 3
  typedef logic [6:0] part_t;

  // weighted or plain sum of the three parts
  typedef logic [9:0] sum_t;

  typedef logic [6:0] result_t;

endpackage

/* design/smc_mode_pkg.sv */
package smc_mode_pkg;

  // ============================================================
  // operating modes
  // ============================================================

  // quantity computed per device
  typedef enum logic {
    QTY_GM = 1'b0,
    QTY_ID = 1'b1
  } qty_e;

  // which half of the sorted list is averaged
  typedef enum logic {
    PICK_SMALL = 1'b0,
    PICK_LARGE = 1'b1
  } pick_e;

  // averaging constants
  localparam int DIVISOR = 3;
  localparam int ID_WEIGHT_HI = 3;
  localparam int ID_WEIGHT_MID = 4;
  localparam int ID_WEIGHT_LO = 5;
  localparam int ID_SHIFT = 2;

endpackage

/* design/mosfet_cell.sv */
`timescale 1ns/1ps

module mosfet_cell
  import smc_types_pkg::*;
  import smc_mode_pkg::*;
(
  input  qty_e    qty,
  input  volt_t   w,
  input  volt_t   vgs,
  input  volt_t   vds,
  output metric_t metric
);

  volt_t      ov;
  logic       triode;
  volt_t      sq_in;
  logic [5:0] sq;
  logic [5:0] two_ov_vds;
  logic [5:0] id_tri;
  logic [5:0] base;

  // overdrive voltage, vgs of 0 is out of range
  assign ov = vgs - 3'd1;

  assign triode = ov > vds;

  // min(ov, vds) squared covers vds^2 in triode and ov^2 in saturation
  assign sq_in = triode ? vds : ov;
  assign sq = 6'(sq_in) * 6'(sq_in);

  // 2*ov*vds - vds^2 is below 64 in triode, so
  // the mod 64 intermediates still give the exact result
  assign two_ov_vds = 6'({ov, 1'b0}) * 6'(vds);
  assign id_tri = two_ov_vds - sq;

  always_comb begin
    if (qty == QTY_ID) begin
      base = triode ? id_tri : sq;
    end else begin
      // gm is 2*vds in triode, 2*ov in saturation
      base = triode ? {2'b00, vds, 1'b0} : {2'b00, ov, 1'b0};
    end
  end

  // scale by device width
  assign metric = metric_t'(base) * metric_t'(w);

endmodule

/* design/mosfet_array.sv */
`timescale 1ns/1ps

module mosfet_array
  import smc_types_pkg::*;
  import smc_mode_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  qty_e    qty,
  input  volt_t   w      [NUM_DEVICES],
  input  volt_t   vgs    [NUM_DEVICES],
  input  volt_t   vds    [NUM_DEVICES],
  output metric_t metric [NUM_DEVICES]
);

  metric_t metric_d [NUM_DEVICES];

  // ============================================================
  // per device Id / gm
  // ============================================================

  for (genvar i = 0; i < NUM_DEVICES; i++) begin : g_dev
    mosfet_cell u_cell (
      .qty    (qty),
      .w      (w[i]),
      .vgs    (vgs[i]),
      .vds    (vds[i]),
      .metric (metric_d[i])
    );

    // vgs of 0 wraps the overdrive and is not a legal input
    a_vgs_nonzero: assert property (
      @(posedge clk) disable iff (rst)
      in_valid |-> vgs[i] != '0
    ) else $error("mosfet_array: device %0d taken with vgs of 0", i);
  end

  // ============================================================
  // stage 1 register
  // ============================================================

  always_ff @(posedge clk) begin
    if (in_valid) begin
      metric <= metric_d;
    end
  end

endmodule

/* design/sort_network.sv */
`timescale 1ns/1ps

module sort_network
  import smc_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    sort_load,
  input  metric_t metric [NUM_DEVICES],
  output metric_t sorted [NUM_DEVICES]
);

  metric_t t [18];
  metric_t n [NUM_DEVICES];

  function automatic metric_t max_of(input metric_t a, input metric_t b);
    return (a > b) ? a : b;
  endfunction

  function automatic metric_t min_of(input metric_t a, input metric_t b);
    return (a > b) ? b : a;
  endfunction

  // ============================================================
  // 12 compare-exchange stages, larger value on the first output
  // ============================================================

  assign t[0]  = max_of(metric[0], metric[5]);
  assign t[1]  = min_of(metric[0], metric[5]);
  assign t[2]  = max_of(metric[1], metric[3]);
  assign t[3]  = min_of(metric[1], metric[3]);
  assign t[4]  = max_of(metric[2], metric[4]);
  assign t[5]  = min_of(metric[2], metric[4]);

  assign t[6]  = max_of(t[2], t[4]);
  assign t[7]  = min_of(t[2], t[4]);
  assign t[8]  = max_of(t[3], t[5]);
  assign t[9]  = min_of(t[3], t[5]);

  assign t[10] = max_of(t[0], t[8]);
  assign t[11] = min_of(t[0], t[8]);
  assign t[12] = max_of(t[7], t[1]);
  assign t[13] = min_of(t[7], t[1]);

  // the overall max and min are settled here
  assign n[0]  = max_of(t[10], t[6]);
  assign t[14] = min_of(t[10], t[6]);
  assign t[15] = max_of(t[12], t[11]);
  assign t[16] = min_of(t[12], t[11]);
  assign t[17] = max_of(t[9], t[13]);
  assign n[5]  = min_of(t[9], t[13]);

  assign n[1]  = max_of(t[14], t[15]);
  assign n[2]  = min_of(t[14], t[15]);
  assign n[3]  = max_of(t[16], t[17]);
  assign n[4]  = min_of(t[16], t[17]);

  // stage 2 register
  always_ff @(posedge clk) begin
    if (sort_load) begin
      sorted <= n;
    end
  end

  for (genvar i = 0; i < NUM_DEVICES - 1; i++) begin : g_order
    a_descending: assert property (
      @(posedge clk) disable iff (rst)
      sort_load |=> sorted[i] >= sorted[i+1]
    ) else $error("sort_network: element %0d below element %0d", i, i + 1);
  end

endmodule

/* design/result_combiner.sv */
`timescale 1ns/1ps

module result_combiner
  import smc_types_pkg::*;
  import smc_mode_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    comb_load,
  input  qty_e    comb_qty,
  input  pick_e   comb_pick,
  input  metric_t sorted [NUM_DEVICES],
  output result_t out_n
);

  metric_t picked [NUM_PICKED];
  part_t   part   [NUM_PICKED];
  sum_t    weighted;
  sum_t    plain;
  sum_t    total;

  // ============================================================
  // pick three and divide each by 3
  // ============================================================

  // element 0 is the largest, so the large pick starts at 0
  always_comb begin
    for (int i = 0; i < NUM_PICKED; i++) begin
      if (comb_pick == PICK_LARGE) begin
        picked[i] = sorted[i];
      end else begin
        picked[i] = sorted[i + NUM_PICKED];
      end
      part[i] = part_t'(picked[i] / DIVISOR);
    end
  end

  // ============================================================
  // weighted Id average or plain gm average
  // ============================================================

  assign weighted = sum_t'(ID_WEIGHT_HI * part[0])
                  + sum_t'(ID_WEIGHT_MID * part[1])
                  + sum_t'(ID_WEIGHT_LO * part[2]);

  assign plain = sum_t'(part[0]) + sum_t'(part[1]) + sum_t'(part[2]);

  assign total = (comb_qty == QTY_ID) ? (weighted >> ID_SHIFT) : plain;

  // stage 3 register, holds between items
  always_ff @(posedge clk) begin
    if (rst) begin
      out_n <= '0;
    end else if (comb_load) begin
      out_n <= result_t'(total / DIVISOR);
    end
  end

endmodule

/* design/smc_ctrl.sv */
`timescale 1ns/1ps

module smc_ctrl
  import smc_mode_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  in_valid,
  input  qty_e  qty,
  input  pick_e pick,
  output logic  sort_load,
  output logic  comb_load,
  output logic  out_valid,
  output qty_e  comb_qty,
  output pick_e comb_pick
);

  logic  [2:0] valid_q;
  qty_e        qty_q;
  pick_e       pick_q;

  // valid strobe, one bit per pipeline stage
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], in_valid};
    end
  end

  assign sort_load = valid_q[0];
  assign comb_load = valid_q[1];
  assign out_valid = valid_q[2];

  // modes follow their item so they can change every cycle
  always_ff @(posedge clk) begin
    qty_q     <= qty;
    pick_q    <= pick;
    comb_qty  <= qty_q;
    comb_pick <= pick_q;
  end

  a_latency: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> $past(in_valid, 3)
  ) else $error("smc_ctrl: out_valid without an item three cycles before");

endmodule

/* design/smc_top.sv */
`timescale 1ns/1ps

module smc_top
  import smc_types_pkg::*;
  import smc_mode_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  qty_e    qty,
  input  pick_e   pick,
  input  volt_t   w   [NUM_DEVICES],
  input  volt_t   vgs [NUM_DEVICES],
  input  volt_t   vds [NUM_DEVICES],
  output logic    out_valid,
  output result_t out_n
);

  logic    sort_load;
  logic    comb_load;
  qty_e    comb_qty;
  pick_e   comb_pick;
  metric_t metric [NUM_DEVICES];
  metric_t sorted [NUM_DEVICES];

  // ============================================================
  // control
  // ============================================================

  smc_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .qty       (qty),
    .pick      (pick),
    .sort_load (sort_load),
    .comb_load (comb_load),
    .out_valid (out_valid),
    .comb_qty  (comb_qty),
    .comb_pick (comb_pick)
  );

  // ============================================================
  // datapath, one register per stage
  // ============================================================

  mosfet_array u_array (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .qty      (qty),
    .w        (w),
    .vgs      (vgs),
    .vds      (vds),
    .metric   (metric)
  );

  sort_network u_sort (
    .clk       (clk),
    .rst       (rst),
    .sort_load (sort_load),
    .metric    (metric),
    .sorted    (sorted)
  );

  result_combiner u_comb (
    .clk       (clk),
    .rst       (rst),
    .comb_load (comb_load),
    .comb_qty  (comb_qty),
    .comb_pick (comb_pick),
    .sorted    (sorted),
    .out_n     (out_n)
  );

endmodule

/* tb/smc_tb.sv */
`timescale 1ns/1ps

module smc_tb
  import smc_types_pkg::*;
  import smc_mode_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 3;
  localparam int N_ITEMS = 400;
  localparam int N_DIRECTED = 12;
  localparam logic [15:0] SEED = 16'd7010;
  // at most two cycles per item, plus reset and drain margin
  localparam int WATCHDOG_NS = (N_ITEMS * 2 + 20) * CLK_PERIOD;

  logic    clk;
  logic    rst;
  logic    in_valid;
  qty_e    qty;
  pick_e   pick;
  volt_t   w   [NUM_DEVICES];
  volt_t   vgs [NUM_DEVICES];
  volt_t   vds [NUM_DEVICES];
  logic    out_valid;
  result_t out_n;

  logic [15:0] lfsr_state;
  logic [2:0]  valid_hist;
  result_t     exp_q [$];
  result_t     exp_n;
  int          value_errors;
  int          timing_errors;
  int          other_errors;

  smc_top smc_top_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .qty       (qty),
    .pick      (pick),
    .w         (w),
    .vgs       (vgs),
    .vds       (vds),
    .out_valid (out_valid),
    .out_n     (out_n)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ============================================================
  // random source and reference model
  // ============================================================

  // 16 bit Galois LFSR, one step per bit taken
  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic int cell_model(input qty_e q, input int wv, input int vg, input int vd);
    int ov;
    int id;
    int gm;
    ov = vg - 1;
    if (ov > vd) begin
      // triode
      id = wv * (2 * ov * vd - vd * vd);
      gm = wv * 2 * vd;
    end else begin
      id = wv * ov * ov;
      gm = wv * 2 * ov;
    end
    return (q == QTY_ID) ? id : gm;
  endfunction

  function automatic int result_model(input qty_e q, input pick_e p);
    int m [NUM_DEVICES];
    int tmp;
    int base;
    int a;
    int b;
    int c;
    for (int i = 0; i < NUM_DEVICES; i++) begin
      m[i] = cell_model(q, int'(w[i]), int'(vgs[i]), int'(vds[i]));
    end
    // descending order
    for (int i = 0; i < NUM_DEVICES; i++) begin
      for (int j = i + 1; j < NUM_DEVICES; j++) begin
        if (m[j] > m[i]) begin
          tmp = m[i];
          m[i] = m[j];
          m[j] = tmp;
        end
      end
    end
    base = (p == PICK_LARGE) ? 0 : 3;
    a = m[base] / 3;
    b = m[base + 1] / 3;
    c = m[base + 2] / 3;
    if (q == QTY_ID) begin
      return ((3 * a + 4 * b + 5 * c) / 4) / 3;
    end
    return (a + b + c) / 3;
  endfunction

  // ============================================================
  // stimulus tasks
  // ============================================================

  task automatic wait_drive_point();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic commit_item();
    in_valid = 1'b1;
    exp_q.push_back(result_t'(result_model(qty, pick)));
  endtask

  task automatic random_item();
    int v;
    // idle cycle before roughly one item in four
    if (draw_bits(2) == 0) begin
      wait_drive_point();
      in_valid = 1'b0;
    end
    wait_drive_point();
    qty = qty_e'(1'(draw_bits(1)));
    pick = pick_e'(1'(draw_bits(1)));
    for (int i = 0; i < NUM_DEVICES; i++) begin
      w[i] = volt_t'(draw_bits(3));
      v = draw_bits(3);
      vgs[i] = volt_t'((v == 0) ? 7 : v);
      vds[i] = volt_t'(draw_bits(3));
    end
    commit_item();
  endtask

  // equal device values to exercise ties in the sort
  task automatic pattern_item(input int pat, input qty_e q, input pick_e p);
    wait_drive_point();
    qty = q;
    pick = p;
    for (int i = 0; i < NUM_DEVICES; i++) begin
      if (pat == 0) begin
        w[i] = 3'd5;
        vgs[i] = 3'd6;
        vds[i] = 3'd2;
      end else if (pat == 1) begin
        w[i] = (i < 3) ? 3'd7 : 3'd3;
        vgs[i] = (i < 3) ? 3'd7 : 3'd4;
        vds[i] = (i < 3) ? 3'd7 : 3'd1;
      end else begin
        w[i] = volt_t'(i % 3 + 2);
        vgs[i] = 3'd7;
        vds[i] = volt_t'(i % 3 + 1);
      end
    end
    commit_item();
  endtask

  // ============================================================
  // checking
  // ============================================================

  // mirror of the three stage valid pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_hist <= '0;
    end else begin
      valid_hist <= {valid_hist[1:0], in_valid};
    end
  end

  // expected value for the item now on out_n
  always @(negedge clk) begin
    if (!rst && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("out_valid is high at %0t but no result is expected", $time);
      end else begin
        exp_n = exp_q.pop_front();
      end
    end
  end

  a_valid_timing: assert property (
    @(posedge clk) disable iff (rst)
    out_valid == valid_hist[2]
  ) else begin
    timing_errors++;
    $display("ERROR %0t out_valid expected %0b actual %0b",
             $time, $sampled(valid_hist[2]), $sampled(out_valid));
  end

  a_result_value: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> out_n == exp_n
  ) else begin
    value_errors++;
    $display("ERROR %0t out_n expected %0d actual %0d",
             $time, $sampled(exp_n), $sampled(out_n));
  end

  initial begin
    #WATCHDOG_NS;
    $display("run timed out after %0d ns with %0d results outstanding",
             WATCHDOG_NS, exp_q.size());
    $display("sim failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    qty = QTY_GM;
    pick = PICK_SMALL;
    for (int i = 0; i < NUM_DEVICES; i++) begin
      w[i] = '0;
      vgs[i] = 3'd1;
      vds[i] = '0;
    end
    lfsr_state = SEED;
    exp_n = '0;
    value_errors = 0;
    timing_errors = 0;
    other_errors = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // directed ties, back to back with every mode pair
    for (int pat = 0; pat < 3; pat++) begin
      for (int m = 0; m < 4; m++) begin
        pattern_item(pat, qty_e'(m[0]), pick_e'(m[1]));
      end
    end
    for (int n = 0; n < N_ITEMS - N_DIRECTED; n++) begin
      random_item();
    end
    wait_drive_point();
    in_valid = 1'b0;

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);

    $display("checks done: %0d value errors, %0d timing errors, %0d other errors",
             value_errors, timing_errors, other_errors);
    if (value_errors + timing_errors + other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/smc_types_pkg.sv
design/smc_mode_pkg.sv
design/mosfet_cell.sv
design/mosfet_array.sv
design/sort_network.sv
design/result_combiner.sv
design/smc_ctrl.sv
design/smc_top.sv
tb/smc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module smc_tb -o smc_sim

./obj_dir/smc_sim | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "sim passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
